// ==== list.f ====
+incdir+verilog
verilog/csr_pkg.sv
verilog/csr_access_decode.sv
verilog/csr_trap_regs.sv
verilog/csr_interrupts.sv
verilog/csr_counters.sv
verilog/csr_read_mux.sv
verilog/csr_file.sv
test/csr_file_chk.sv
test/csr_file_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the csr file testbench with verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module csr_file_tb -f list.f

# the simulator exits nonzero on a failure, the log decides the result
./obj_dir/Vcsr_file_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test passed" sim.log; then
  exit 0
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi

// ==== test/csr_file_chk.sv ====
// ============================================================
// csr file checker
// concurrent assertions on trap entry, interrupts and access flags
// ============================================================
`timescale 1ns/1ps

module csr_file_chk (
  input logic              clk,
  input logic              nreset,
  input csr_pkg::csr_cmd_e cmd,
  input logic              illegal_access,
  input logic              exception,
  input csr_pkg::prv_e     prv,
  input logic              interrupt_pending,
  input logic              interrupt_taken
);

  // trap entry always lands in machine mode
  exc_to_machine: assert property (@(posedge clk) disable iff (!nreset)
    exception |=> (prv == csr_pkg::PRV_M))
    else $error("prv is not machine mode in the cycle after an exception");

  taken_needs_pending: assert property (@(posedge clk) disable iff (!nreset)
    interrupt_taken |-> interrupt_pending)
    else $error("interrupt taken without a pending interrupt");

  // an idle port never faults
  idle_is_legal: assert property (@(posedge clk) disable iff (!nreset)
    (cmd == csr_pkg::CSR_IDLE) |-> !illegal_access)
    else $error("illegal access flagged while the port is idle");

endmodule

// ==== test/csr_file_tb.sv ====
// ============================================================
// csr file testbench
// random csr traffic, traps, mret and interrupt sources
// checked every cycle against a register model
// ============================================================
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_file_tb;

  localparam int          N_OPS      = 2000;
  localparam int          MAX_CYCLES = N_OPS + 500;   // reset plus slack
  localparam logic [31:0] SEED       = 32'd53;

  localparam logic [`CSR_ADDR_WIDTH-1:0] KNOWN_ADDRS [20] = '{
    `CSR_ADDR_MSTATUS, `CSR_ADDR_MISA, `CSR_ADDR_MTVEC, `CSR_ADDR_MSCRATCH,
    `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE, `CSR_ADDR_MTVAL, `CSR_ADDR_MIP,
    `CSR_ADDR_MCYCLE, `CSR_ADDR_MCYCLEH, `CSR_ADDR_MINSTRET, `CSR_ADDR_MINSTRETH,
    `CSR_ADDR_CYCLE, `CSR_ADDR_CYCLEH, `CSR_ADDR_INSTRET, `CSR_ADDR_INSTRETH,
    `CSR_ADDR_MVENDORID, `CSR_ADDR_MARCHID, `CSR_ADDR_MIMPID, `CSR_ADDR_MHARTID
  };

  localparam csr_pkg::cause_e EXC_CODES [10] = '{
    csr_pkg::INST_ADDR_MISALIGNED, csr_pkg::INST_ACCESS_FAULT, csr_pkg::ILLEGAL_INST,
    csr_pkg::BREAKPOINT, csr_pkg::LOAD_ADDR_MISALIGNED, csr_pkg::LOAD_ACCESS_FAULT,
    csr_pkg::STORE_ADDR_MISALIGNED, csr_pkg::STORE_ACCESS_FAULT, csr_pkg::ECALL_U,
    csr_pkg::ECALL_M
  };

  logic                       clk;
  logic                       nreset;
  logic                       timer_tick;
  logic [`CSR_N_EXT_INTS-1:0] ext_interrupts;
  logic [`CSR_ADDR_WIDTH-1:0] addr;
  csr_pkg::csr_cmd_e          cmd;
  logic [`XLEN-1:0]           wdata;
  logic                       retire;
  logic                       exception;
  csr_pkg::cause_e            exception_code;
  logic                       exception_int;
  logic                       mret;
  logic [`XLEN-1:0]           exception_pc;
  logic [`XLEN-1:0]           exception_addr;
  logic [`XLEN-1:0]           rdata;
  logic                       illegal_access;
  csr_pkg::prv_e              prv;
  logic [`XLEN-1:0]           handler_pc;
  logic [`XLEN-1:0]           mepc;
  logic                       interrupt_pending;
  logic                       interrupt_taken;
  csr_pkg::cause_e            interrupt_code;

  logic [31:0] lcg_state;
  int          cycle_count = 0;
  int          n_reads = 0;       // legal reads compared

  // model state
  csr_pkg::prv_e m_prv;
  csr_pkg::prv_e m_mpp;
  logic          m_mie;
  logic          m_mpie;
  logic          m_msip;
  logic          m_mtip;
  logic          m_meip;
  logic [31:0]   m_mtvec;
  logic [31:0]   m_mepc;
  logic [31:0]   m_mcause;
  logic [31:0]   m_mtval;
  logic [31:0]   m_mscratch;
  logic [63:0]   m_cycle;
  logic [63:0]   m_instret;

  csr_file dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ============================================================
  // random numbers and failure reporting
  // ============================================================
  function automatic logic [15:0] rand16();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];   // low bits of an lcg are weak
  endfunction

  function automatic logic [31:0] rand32();
    logic [15:0] hi;
    hi = rand16();
    return {hi, rand16()};
  endfunction

  task automatic stop_with_failure();
    $display("Test failed");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %0t ns: %s is %h, expected %h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_prv(input string what, input csr_pkg::prv_e got,
                           input csr_pkg::prv_e exp);
    if (got !== exp) begin
      $display("ERROR %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_cause(input string what, input csr_pkg::cause_e got,
                             input csr_pkg::cause_e exp);
    if (got !== exp) begin
      $display("ERROR %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR %0t ns: %s is %b, expected %b", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  // ============================================================
  // register model
  // ============================================================
  function automatic logic is_defined(input logic [11:0] a);
    foreach (KNOWN_ADDRS[i])
      if (KNOWN_ADDRS[i] == a) return 1'b1;
    return 1'b0;
  endfunction

  function automatic logic is_write(input csr_pkg::csr_cmd_e c);
    return (c == csr_pkg::CSR_WRITE) || (c == csr_pkg::CSR_SET) || (c == csr_pkg::CSR_CLEAR);
  endfunction

  function automatic logic model_illegal(input logic [11:0] a, input csr_pkg::csr_cmd_e c,
                                         input csr_pkg::prv_e p);
    if (c == csr_pkg::CSR_IDLE) return 1'b0;
    return !is_defined(a) || (is_write(c) && (a[11:10] == 2'b11)) || (a[9:8] > p);
  endfunction

  function automatic logic [31:0] model_read(input logic [11:0] a);
    case (a)
      `CSR_ADDR_MSTATUS:  return {19'd0, m_mpp, 3'd0, m_mpie, 3'd0, m_mie, 3'd0};
      `CSR_ADDR_MISA:     return `CSR_MISA_VALUE;
      `CSR_ADDR_MTVEC:    return m_mtvec;
      `CSR_ADDR_MSCRATCH: return m_mscratch;
      `CSR_ADDR_MEPC:     return m_mepc;
      `CSR_ADDR_MCAUSE:   return m_mcause;
      `CSR_ADDR_MTVAL:    return m_mtval;
      `CSR_ADDR_MIP:      return {20'd0, m_meip, 3'd0, m_mtip, 3'd0, m_msip, 3'd0};
      `CSR_ADDR_MCYCLE, `CSR_ADDR_CYCLE:       return m_cycle[31:0];
      `CSR_ADDR_MCYCLEH, `CSR_ADDR_CYCLEH:     return m_cycle[63:32];
      `CSR_ADDR_MINSTRET, `CSR_ADDR_INSTRET:   return m_instret[31:0];
      `CSR_ADDR_MINSTRETH, `CSR_ADDR_INSTRETH: return m_instret[63:32];
      `CSR_ADDR_MVENDORID: return `CSR_VENDOR_ID;
      `CSR_ADDR_MARCHID:   return `CSR_ARCH_ID;
      `CSR_ADDR_MIMPID:    return `CSR_IMPL_ID;
      `CSR_ADDR_MHARTID:   return `CSR_HART_ID;
      default:             return 32'd0;
    endcase
  endfunction

  task automatic reset_model();
    m_prv      = csr_pkg::PRV_M;
    m_mpp      = csr_pkg::PRV_U;
    m_mie      = 1'b0;
    m_mpie     = 1'b1;
    m_msip     = 1'b0;
    m_mtip     = 1'b0;
    m_meip     = 1'b0;
    m_mtvec    = `CSR_BOOT_ADDR;
    m_mepc     = `CSR_BOOT_ADDR;
    m_mcause   = 32'd0;
    m_mtval    = 32'd0;
    m_mscratch = 32'd0;
    m_cycle    = 64'd0;
    m_instret  = 64'd0;
  endtask

  // next state from the inputs held during this cycle
  task automatic step_model();
    logic [31:0]   old_val;
    logic [31:0]   new_val;
    logic          wr;
    csr_pkg::prv_e old_prv;
    old_val = model_read(addr);
    old_prv = m_prv;
    wr = is_write(cmd) && !model_illegal(addr, cmd, m_prv);
    case (cmd)
      csr_pkg::CSR_SET:   new_val = old_val | wdata;
      csr_pkg::CSR_CLEAR: new_val = old_val & ~wdata;
      default:            new_val = wdata;
    endcase
    if (exception)
      m_prv = csr_pkg::PRV_M;
    else if (mret)
      m_prv = m_mpp;
    if (wr && (addr == `CSR_ADDR_MSTATUS)) begin
      m_mie  = new_val[3];
      m_mpie = new_val[7];
      if ((new_val[12:11] == 2'd0) || (new_val[12:11] == 2'd3))
        m_mpp = csr_pkg::prv_e'(new_val[12:11]);
    end else if (exception) begin
      m_mpp  = old_prv;
      m_mpie = m_mie;
      m_mie  = 1'b0;
    end else if (mret) begin
      m_mie  = m_mpie;
      m_mpie = 1'b1;
      m_mpp  = csr_pkg::PRV_U;
    end
    if (wr && (addr == `CSR_ADDR_MTVEC)) m_mtvec = {new_val[31:2], 2'b00};
    if (wr && (addr == `CSR_ADDR_MSCRATCH)) m_mscratch = new_val;
    if (wr && (addr == `CSR_ADDR_MEPC)) m_mepc = new_val;
    else if (exception) m_mepc = {exception_pc[31:1], 1'b0};
    if (wr && (addr == `CSR_ADDR_MCAUSE)) m_mcause = new_val;
    else if (exception) m_mcause = {exception_int, 27'd0, exception_code};
    if (wr && (addr == `CSR_ADDR_MTVAL)) begin
      m_mtval = new_val;
    end else if (exception) begin
      case (exception_code)
        csr_pkg::INST_ADDR_MISALIGNED, csr_pkg::INST_ACCESS_FAULT: m_mtval = exception_pc;
        csr_pkg::LOAD_ADDR_MISALIGNED, csr_pkg::LOAD_ACCESS_FAULT,
        csr_pkg::STORE_ADDR_MISALIGNED, csr_pkg::STORE_ACCESS_FAULT: m_mtval = exception_addr;
        default: ;   // other causes keep mtval
      endcase
    end
    m_mtip = timer_tick;
    m_meip = |ext_interrupts;
    if (wr && (addr == `CSR_ADDR_MIP)) m_msip = new_val[3];
    if (wr && (addr == `CSR_ADDR_MCYCLE)) m_cycle[31:0] = new_val;
    else if (wr && (addr == `CSR_ADDR_MCYCLEH)) m_cycle[63:32] = new_val;
    else m_cycle = m_cycle + 64'd1;
    if (wr && (addr == `CSR_ADDR_MINSTRET)) m_instret[31:0] = new_val;
    else if (wr && (addr == `CSR_ADDR_MINSTRETH)) m_instret[63:32] = new_val;
    else if (retire) m_instret = m_instret + 64'd1;
  endtask

  task automatic check_outputs();
    logic exp_illegal;
    logic exp_pending;
    exp_illegal = model_illegal(addr, cmd, m_prv);
    exp_pending = m_msip | m_mtip | m_meip;
    check_flag("illegal_access", illegal_access, exp_illegal);
    if ((cmd != csr_pkg::CSR_IDLE) && !exp_illegal) begin
      check_word("rdata", rdata, model_read(addr));
      n_reads++;
    end
    check_prv("prv", prv, m_prv);
    check_word("handler_pc", handler_pc, m_mtvec);
    check_word("mepc", mepc, m_mepc);
    check_flag("interrupt_pending", interrupt_pending, exp_pending);
    check_flag("interrupt_taken", interrupt_taken,
               exp_pending && ((m_prv == csr_pkg::PRV_U) || m_mie));
    if (exp_pending)
      check_cause("interrupt_code", interrupt_code,
                  m_mtip ? csr_pkg::TIMER_INT_M : (m_meip ? csr_pkg::EXT_INT_M
                                                          : csr_pkg::SOFT_INT_M));
  endtask

  // ============================================================
  // stimulus
  // ============================================================
  task automatic drive_op();
    logic [15:0] r;
    logic [15:0] v;
    logic [15:0] a;
    r = rand16();
    v = rand16();
    cmd       <= csr_pkg::CSR_IDLE;
    exception <= 1'b0;
    mret      <= 1'b0;
    retire    <= r[8];
    if (r[3:0] < 4'd8) begin
      case (v[1:0])
        2'd0:    cmd <= csr_pkg::CSR_READ;
        2'd1:    cmd <= csr_pkg::CSR_WRITE;
        2'd2:    cmd <= csr_pkg::CSR_SET;
        default: cmd <= csr_pkg::CSR_CLEAR;
      endcase
      if (v[4:2] == 3'd0) begin
        a = rand16();
        addr <= a[`CSR_ADDR_WIDTH-1:0];   // mostly undefined addresses
      end else begin
        addr <= KNOWN_ADDRS[v[15:8] % 20];
      end
      wdata <= rand32();
    end else if (r[3:0] == 4'd10) begin
      mret <= 1'b1;
    end else if (r[3:0] == 4'd11) begin
      timer_tick <= ~timer_tick;
    end else if (r[3:0] == 4'd12) begin
      ext_interrupts <= v[3:0];
    end
    // exceptions also land on top of csr commands
    if ((r[3:0] == 4'd8) || (r[3:0] == 4'd9) || (r[15:12] == 4'hf)) begin
      exception      <= 1'b1;
      exception_code <= EXC_CODES[v[15:8] % 10];
      exception_pc   <= rand32();
      exception_addr <= rand32();
    end
  endtask

  initial begin
    lcg_state      = SEED;
    nreset         = 1'b0;
    timer_tick     = 1'b0;
    ext_interrupts = '0;
    addr           = '0;
    cmd            = csr_pkg::CSR_IDLE;
    wdata          = '0;
    retire         = 1'b0;
    exception      = 1'b0;
    exception_code = csr_pkg::INST_ADDR_MISALIGNED;
    exception_int  = 1'b0;
    mret           = 1'b0;
    exception_pc   = '0;
    exception_addr = '0;
    reset_model();
    repeat (2) @(posedge clk);
    nreset <= 1'b1;
    for (int n = 0; n < N_OPS; n++) begin
      @(negedge clk);
      check_outputs();
      step_model();
      @(posedge clk);
      drive_op();
    end
    @(negedge clk);
    check_outputs();
    if (n_reads > 0) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("no legal csr read was ever compared");
      stop_with_failure();
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: the test did not finish within %0d cycles", MAX_CYCLES);
      stop_with_failure();
    end
  end

endmodule

bind csr_file csr_file_chk chk0 (
  .clk(clk),
  .nreset(nreset),
  .cmd(cmd),
  .illegal_access(illegal_access),
  .exception(exception),
  .prv(prv),
  .interrupt_pending(interrupt_pending),
  .interrupt_taken(interrupt_taken)
);

// ==== verilog/csr_access_decode.sv ====
// =========================================================
// csr access decode
// address to register select, access checks and merged write value
// =========================================================
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_access_decode (
  input  logic [`CSR_ADDR_WIDTH-1:0] addr,
  input  csr_pkg::csr_cmd_e          cmd,
  input  logic [`XLEN-1:0]           wdata,
  input  logic [`XLEN-1:0]           rdata,    // current value, for set and clear
  input  csr_pkg::prv_e              prv,
  output csr_pkg::csr_sel_e          sel,
  output logic                       wen,
  output logic [`XLEN-1:0]           wr_value,
  output logic                       illegal_access
);

  logic active;     // any command but idle
  logic is_write;   // write, set or clear

  always_comb begin
    case (addr)
      `CSR_ADDR_MSTATUS:   sel = csr_pkg::SEL_MSTATUS;
      `CSR_ADDR_MISA:      sel = csr_pkg::SEL_MISA;
      `CSR_ADDR_MTVEC:     sel = csr_pkg::SEL_MTVEC;
      `CSR_ADDR_MSCRATCH:  sel = csr_pkg::SEL_MSCRATCH;
      `CSR_ADDR_MEPC:      sel = csr_pkg::SEL_MEPC;
      `CSR_ADDR_MCAUSE:    sel = csr_pkg::SEL_MCAUSE;
      `CSR_ADDR_MTVAL:     sel = csr_pkg::SEL_MTVAL;
      `CSR_ADDR_MIP:       sel = csr_pkg::SEL_MIP;
      `CSR_ADDR_MCYCLE:    sel = csr_pkg::SEL_MCYCLE;
      `CSR_ADDR_MCYCLEH:   sel = csr_pkg::SEL_MCYCLEH;
      `CSR_ADDR_MINSTRET:  sel = csr_pkg::SEL_MINSTRET;
      `CSR_ADDR_MINSTRETH: sel = csr_pkg::SEL_MINSTRETH;
      `CSR_ADDR_CYCLE:     sel = csr_pkg::SEL_CYCLE;
      `CSR_ADDR_CYCLEH:    sel = csr_pkg::SEL_CYCLEH;
      `CSR_ADDR_INSTRET:   sel = csr_pkg::SEL_INSTRET;
      `CSR_ADDR_INSTRETH:  sel = csr_pkg::SEL_INSTRETH;
      `CSR_ADDR_MVENDORID: sel = csr_pkg::SEL_MVENDORID;
      `CSR_ADDR_MARCHID:   sel = csr_pkg::SEL_MARCHID;
      `CSR_ADDR_MIMPID:    sel = csr_pkg::SEL_MIMPID;
      `CSR_ADDR_MHARTID:   sel = csr_pkg::SEL_MHARTID;
      default:             sel = csr_pkg::SEL_NONE;
    endcase
  end

  assign active   = (cmd != csr_pkg::CSR_IDLE);
  assign is_write = (cmd == csr_pkg::CSR_WRITE) || (cmd == csr_pkg::CSR_SET) ||
                    (cmd == csr_pkg::CSR_CLEAR);

  // undefined address, write to read-only space, or privilege too low
  assign illegal_access = active && ((sel == csr_pkg::SEL_NONE) ||
                                     (is_write && (addr[11:10] == 2'b11)) ||
                                     (addr[9:8] > prv));

  assign wen = is_write && !illegal_access;

  always_comb begin
    case (cmd)
      csr_pkg::CSR_SET:   wr_value = rdata | wdata;
      csr_pkg::CSR_CLEAR: wr_value = rdata & ~wdata;
      default:            wr_value = wdata;
    endcase
  end

endmodule

// ==== verilog/csr_counters.sv ====
// =========================================================
// csr counters
// 64-bit cycle and instret with half-word writes
// =========================================================
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_counters (
  input  logic                          clk,
  input  logic                          nreset,
  input  csr_pkg::csr_sel_e             sel,
  input  logic                          wen,
  input  logic [`XLEN-1:0]              wr_value,
  input  logic                          retire,
  output logic [`CSR_COUNTER_WIDTH-1:0] cycle,
  output logic [`CSR_COUNTER_WIDTH-1:0] instret
);

  // index 0 is cycle, index 1 is instret
  logic [`CSR_COUNTER_WIDTH-1:0] count [2];
  logic [1:0]                    wr_lo;
  logic [1:0]                    wr_hi;
  logic [1:0]                    inc;

  assign wr_lo = {wen && (sel == csr_pkg::SEL_MINSTRET),
                  wen && (sel == csr_pkg::SEL_MCYCLE)};
  assign wr_hi = {wen && (sel == csr_pkg::SEL_MINSTRETH),
                  wen && (sel == csr_pkg::SEL_MCYCLEH)};
  assign inc   = {retire, 1'b1};

  for (genvar i = 0; i < 2; i++) begin : g_counter
    always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
        count[i] <= '0;
      end else if (wr_lo[i]) begin
        count[i][`XLEN-1:0] <= wr_value;  // a written half skips the increment
      end else if (wr_hi[i]) begin
        count[i][`CSR_COUNTER_WIDTH-1:`XLEN] <= wr_value;
      end else if (inc[i]) begin
        count[i] <= count[i] + 1'b1;
      end
    end
  end

  assign cycle   = count[0];
  assign instret = count[1];

endmodule

// ==== verilog/csr_file.sv ====
// =========================================================
// csr file top level
// machine-mode CSR file of a small rv32 core
// =========================================================
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_file (
  input  logic                       clk,
  input  logic                       nreset,
  input  logic                       timer_tick,
  input  logic [`CSR_N_EXT_INTS-1:0] ext_interrupts,
  input  logic [`CSR_ADDR_WIDTH-1:0] addr,
  input  csr_pkg::csr_cmd_e          cmd,
  input  logic [`XLEN-1:0]           wdata,
  input  logic                       retire,
  input  logic                       exception,
  input  csr_pkg::cause_e            exception_code,
  input  logic                       exception_int,
  input  logic                       mret,
  input  logic [`XLEN-1:0]           exception_pc,
  input  logic [`XLEN-1:0]           exception_addr,
  output logic [`XLEN-1:0]           rdata,
  output logic                       illegal_access,
  output csr_pkg::prv_e              prv,
  output logic [`XLEN-1:0]           handler_pc,
  output logic [`XLEN-1:0]           mepc,
  output logic                       interrupt_pending,
  output logic                       interrupt_taken,
  output csr_pkg::cause_e            interrupt_code
);

  csr_pkg::csr_sel_e             sel;
  logic                          wen;
  logic [`XLEN-1:0]              wr_value;
  logic                          mie;
  logic [`XLEN-1:0]              mstatus;
  logic [`XLEN-1:0]              mtvec;
  logic [`XLEN-1:0]              mcause;
  logic [`XLEN-1:0]              mtval;
  logic [`XLEN-1:0]              mscratch;
  logic [`XLEN-1:0]              mip;
  logic [`CSR_COUNTER_WIDTH-1:0] cycle;
  logic [`CSR_COUNTER_WIDTH-1:0] instret;

  csr_access_decode decode0 (
    .addr(addr), .cmd(cmd), .wdata(wdata), .rdata(rdata), .prv(prv),
    .sel(sel), .wen(wen), .wr_value(wr_value), .illegal_access(illegal_access)
  );

  csr_trap_regs trap0 (
    .clk(clk), .nreset(nreset), .sel(sel), .wen(wen), .wr_value(wr_value),
    .exception(exception), .exception_code(exception_code),
    .exception_int(exception_int), .mret(mret), .exception_pc(exception_pc),
    .exception_addr(exception_addr), .prv(prv), .mie(mie), .mstatus(mstatus),
    .mtvec(mtvec), .mepc(mepc), .mcause(mcause), .mtval(mtval),
    .mscratch(mscratch), .handler_pc(handler_pc)
  );

  csr_interrupts irq0 (
    .clk(clk), .nreset(nreset), .timer_tick(timer_tick),
    .ext_interrupts(ext_interrupts), .sel(sel), .wen(wen), .wr_value(wr_value),
    .mie(mie), .prv(prv), .mip(mip), .interrupt_pending(interrupt_pending),
    .interrupt_taken(interrupt_taken), .interrupt_code(interrupt_code)
  );

  csr_counters cnt0 (
    .clk(clk), .nreset(nreset), .sel(sel), .wen(wen), .wr_value(wr_value),
    .retire(retire), .cycle(cycle), .instret(instret)
  );

  csr_read_mux rmux0 (
    .sel(sel), .prv(prv), .mstatus(mstatus), .mtvec(mtvec), .mepc(mepc),
    .mcause(mcause), .mtval(mtval), .mscratch(mscratch), .mip(mip),
    .cycle(cycle), .instret(instret), .rdata(rdata)
  );

endmodule

// ==== verilog/csr_interrupts.sv ====
// =========================================================
// csr interrupts
// mip sampling, pending and taken flags, priority cause code
// =========================================================
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_interrupts (
  input  logic                       clk,
  input  logic                       nreset,
  input  logic                       timer_tick,
  input  logic [`CSR_N_EXT_INTS-1:0] ext_interrupts,
  input  csr_pkg::csr_sel_e          sel,
  input  logic                       wen,
  input  logic [`XLEN-1:0]           wr_value,
  input  logic                       mie,
  input  csr_pkg::prv_e              prv,
  output logic [`XLEN-1:0]           mip,
  output logic                       interrupt_pending,
  output logic                       interrupt_taken,
  output csr_pkg::cause_e            interrupt_code
);

  logic msip;   // software, written through the csr port
  logic mtip;   // timer, sampled
  logic meip;   // external, sampled

  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      msip <= 1'b0;
      mtip <= 1'b0;
      meip <= 1'b0;
    end else begin
      mtip <= timer_tick;
      meip <= |ext_interrupts;
      if (wen && (sel == csr_pkg::SEL_MIP))
        msip <= wr_value[3];
    end
  end

  assign mip = {{(`XLEN-12){1'b0}}, meip, 3'b000, mtip, 3'b000, msip, 3'b000};

  assign interrupt_pending = msip | mtip | meip;
  // user mode always takes machine interrupts
  assign interrupt_taken   = interrupt_pending && ((prv == csr_pkg::PRV_U) || mie);

  always_comb begin
    if (mtip)
      interrupt_code = csr_pkg::TIMER_INT_M;
    else if (meip)
      interrupt_code = csr_pkg::EXT_INT_M;
    else
      interrupt_code = csr_pkg::SOFT_INT_M;
  end

endmodule

// ==== verilog/csr_params.svh ====
// =========================================================
// csr file parameters
// widths, machine CSR addresses, identification and reset values
// =========================================================
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

`define XLEN              32
`define CSR_ADDR_WIDTH    12
`define CSR_CMD_WIDTH     3
`define CSR_SEL_WIDTH     5
`define CAUSE_WIDTH       4
`define CSR_COUNTER_WIDTH 64
`define CSR_N_EXT_INTS    4

// machine trap setup and handling
`define CSR_ADDR_MSTATUS   12'h300
`define CSR_ADDR_MISA      12'h301
`define CSR_ADDR_MTVEC     12'h305
`define CSR_ADDR_MSCRATCH  12'h340
`define CSR_ADDR_MEPC      12'h341
`define CSR_ADDR_MCAUSE    12'h342
`define CSR_ADDR_MTVAL     12'h343
`define CSR_ADDR_MIP       12'h344

// counters, machine copies are writable, user copies are read-only
`define CSR_ADDR_MCYCLE    12'hb00
`define CSR_ADDR_MINSTRET  12'hb02
`define CSR_ADDR_MCYCLEH   12'hb80
`define CSR_ADDR_MINSTRETH 12'hb82
`define CSR_ADDR_CYCLE     12'hc00
`define CSR_ADDR_INSTRET   12'hc02
`define CSR_ADDR_CYCLEH    12'hc80
`define CSR_ADDR_INSTRETH  12'hc82

// identification
`define CSR_ADDR_MVENDORID 12'hf11
`define CSR_ADDR_MARCHID   12'hf12
`define CSR_ADDR_MIMPID    12'hf13
`define CSR_ADDR_MHARTID   12'hf14

`define CSR_BOOT_ADDR      32'h8000_0000
`define CSR_MISA_VALUE     32'h4010_1104  // rv32 with i, m, c and u
`define CSR_VENDOR_ID      32'h0000_0000
`define CSR_ARCH_ID        32'd31
`define CSR_IMPL_ID        32'h0000_0001
`define CSR_HART_ID        32'h0000_0000

`endif

// ==== verilog/csr_pkg.sv ====
// =========================================================
// csr package
// command, privilege, register select and cause code types
// =========================================================
`include "csr_params.svh"

package csr_pkg;

  typedef enum logic [`CSR_CMD_WIDTH-1:0] {
    CSR_IDLE  = 3'd0,
    CSR_READ  = 3'd4,
    CSR_WRITE = 3'd5,
    CSR_SET   = 3'd6,
    CSR_CLEAR = 3'd7
  } csr_cmd_e;

  typedef enum logic [1:0] {
    PRV_U = 2'd0,
    PRV_M = 2'd3
  } prv_e;

  // one value per register, counter halves count separately
  typedef enum logic [`CSR_SEL_WIDTH-1:0] {
    SEL_NONE,
    SEL_MSTATUS, SEL_MISA, SEL_MTVEC, SEL_MSCRATCH,
    SEL_MEPC, SEL_MCAUSE, SEL_MTVAL, SEL_MIP,
    SEL_MCYCLE, SEL_MCYCLEH, SEL_MINSTRET, SEL_MINSTRETH,
    SEL_MVENDORID, SEL_MARCHID, SEL_MIMPID, SEL_MHARTID
  } csr_sel_e;

  // user counter names select the machine counters
  localparam csr_sel_e SEL_CYCLE    = SEL_MCYCLE;
  localparam csr_sel_e SEL_CYCLEH   = SEL_MCYCLEH;
  localparam csr_sel_e SEL_INSTRET  = SEL_MINSTRET;
  localparam csr_sel_e SEL_INSTRETH = SEL_MINSTRETH;

  typedef enum logic [`CAUSE_WIDTH-1:0] {
    INST_ADDR_MISALIGNED  = 4'd0,
    INST_ACCESS_FAULT     = 4'd1,
    ILLEGAL_INST          = 4'd2,
    BREAKPOINT            = 4'd3,
    LOAD_ADDR_MISALIGNED  = 4'd4,
    LOAD_ACCESS_FAULT     = 4'd5,
    STORE_ADDR_MISALIGNED = 4'd6,
    STORE_ACCESS_FAULT    = 4'd7,
    ECALL_U               = 4'd8,
    ECALL_M               = 4'd11
  } cause_e;

  // interrupt codes reuse exception numbers, mcause bit 31 tells them apart
  localparam cause_e SOFT_INT_M  = BREAKPOINT;
  localparam cause_e TIMER_INT_M = STORE_ACCESS_FAULT;
  localparam cause_e EXT_INT_M   = ECALL_M;

endpackage

// ==== verilog/csr_read_mux.sv ====
// =========================================================
// csr read mux
// selects the read data, counters split into halves
// =========================================================
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_read_mux (
  input  csr_pkg::csr_sel_e             sel,
  input  csr_pkg::prv_e                 prv,
  input  logic [`XLEN-1:0]              mstatus,
  input  logic [`XLEN-1:0]              mtvec,
  input  logic [`XLEN-1:0]              mepc,
  input  logic [`XLEN-1:0]              mcause,
  input  logic [`XLEN-1:0]              mtval,
  input  logic [`XLEN-1:0]              mscratch,
  input  logic [`XLEN-1:0]              mip,
  input  logic [`CSR_COUNTER_WIDTH-1:0] cycle,
  input  logic [`CSR_COUNTER_WIDTH-1:0] instret,
  output logic [`XLEN-1:0]              rdata
);

  logic counter_sel;   // the only registers user mode may see

  assign counter_sel = (sel == csr_pkg::SEL_MCYCLE) || (sel == csr_pkg::SEL_MCYCLEH) ||
                       (sel == csr_pkg::SEL_MINSTRET) || (sel == csr_pkg::SEL_MINSTRETH);

  always_comb begin
    case (sel)
      csr_pkg::SEL_MSTATUS:   rdata = mstatus;
      csr_pkg::SEL_MISA:      rdata = `CSR_MISA_VALUE;
      csr_pkg::SEL_MTVEC:     rdata = mtvec;
      csr_pkg::SEL_MSCRATCH:  rdata = mscratch;
      csr_pkg::SEL_MEPC:      rdata = mepc;
      csr_pkg::SEL_MCAUSE:    rdata = mcause;
      csr_pkg::SEL_MTVAL:     rdata = mtval;
      csr_pkg::SEL_MIP:       rdata = mip;
      csr_pkg::SEL_MCYCLE:    rdata = cycle[`XLEN-1:0];
      csr_pkg::SEL_MCYCLEH:   rdata = cycle[`CSR_COUNTER_WIDTH-1:`XLEN];
      csr_pkg::SEL_MINSTRET:  rdata = instret[`XLEN-1:0];
      csr_pkg::SEL_MINSTRETH: rdata = instret[`CSR_COUNTER_WIDTH-1:`XLEN];
      csr_pkg::SEL_MVENDORID: rdata = `CSR_VENDOR_ID;
      csr_pkg::SEL_MARCHID:   rdata = `CSR_ARCH_ID;
      csr_pkg::SEL_MIMPID:    rdata = `CSR_IMPL_ID;
      csr_pkg::SEL_MHARTID:   rdata = `CSR_HART_ID;
      default:                rdata = '0;   // undefined address
    endcase
    // machine state does not leak to user mode
    if ((prv == csr_pkg::PRV_U) && !counter_sel)
      rdata = '0;
  end

endmodule

// ==== verilog/csr_trap_regs.sv ====
// =========================================================
// csr trap registers
// privilege stack, trap vector and trap state with entry and mret
// =========================================================
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_trap_regs (
  input  logic                    clk,
  input  logic                    nreset,
  input  csr_pkg::csr_sel_e       sel,
  input  logic                    wen,
  input  logic [`XLEN-1:0]        wr_value,
  input  logic                    exception,
  input  csr_pkg::cause_e         exception_code,
  input  logic                    exception_int,
  input  logic                    mret,
  input  logic [`XLEN-1:0]        exception_pc,
  input  logic [`XLEN-1:0]        exception_addr,
  output csr_pkg::prv_e           prv,
  output logic                    mie,
  output logic [`XLEN-1:0]        mstatus,
  output logic [`XLEN-1:0]        mtvec,
  output logic [`XLEN-1:0]        mepc,
  output logic [`XLEN-1:0]        mcause,
  output logic [`XLEN-1:0]        mtval,
  output logic [`XLEN-1:0]        mscratch,
  output logic [`XLEN-1:0]        handler_pc
);

  logic          mpie;
  csr_pkg::prv_e mpp;
  logic          inst_fault;    // mtval takes the pc
  logic          mem_fault;     // mtval takes the data address

  assign mstatus    = {{(`XLEN-13){1'b0}}, mpp, 3'b000, mpie, 3'b000, mie, 3'b000};
  assign handler_pc = mtvec;

  assign inst_fault = (exception_code == csr_pkg::INST_ADDR_MISALIGNED) ||
                      (exception_code == csr_pkg::INST_ACCESS_FAULT);
  assign mem_fault  = (exception_code == csr_pkg::LOAD_ADDR_MISALIGNED) ||
                      (exception_code == csr_pkg::LOAD_ACCESS_FAULT) ||
                      (exception_code == csr_pkg::STORE_ADDR_MISALIGNED) ||
                      (exception_code == csr_pkg::STORE_ACCESS_FAULT);

  // =========================================================
  // privilege and mstatus stack
  // =========================================================
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      prv <= csr_pkg::PRV_M;
    end else if (exception) begin
      prv <= csr_pkg::PRV_M;
    end else if (mret) begin
      prv <= mpp;
    end
  end

  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      mie  <= 1'b0;
      mpie <= 1'b1;
      mpp  <= csr_pkg::PRV_U;
    end else if (wen && (sel == csr_pkg::SEL_MSTATUS)) begin
      mie  <= wr_value[3];
      mpie <= wr_value[7];
      // mpp is warl, only u and m are kept
      if ((wr_value[12:11] == csr_pkg::PRV_U) || (wr_value[12:11] == csr_pkg::PRV_M))
        mpp <= csr_pkg::prv_e'(wr_value[12:11]);
    end else if (exception) begin
      mpp  <= prv;
      mpie <= mie;
      mie  <= 1'b0;
    end else if (mret) begin
      mie  <= mpie;
      mpie <= 1'b1;
      mpp  <= csr_pkg::PRV_U;
    end
  end

  // =========================================================
  // trap vector, epc, cause, tval and scratch
  // =========================================================
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      mtvec    <= `CSR_BOOT_ADDR;
      mepc     <= `CSR_BOOT_ADDR;
      mcause   <= '0;
      mtval    <= '0;
      mscratch <= '0;
    end else begin
      if (wen && (sel == csr_pkg::SEL_MTVEC))
        mtvec <= {wr_value[`XLEN-1:2], 2'b00};  // direct mode only
      if (wen && (sel == csr_pkg::SEL_MSCRATCH))
        mscratch <= wr_value;
      if (wen && (sel == csr_pkg::SEL_MEPC))
        mepc <= wr_value;
      else if (exception)
        mepc <= {exception_pc[`XLEN-1:1], 1'b0};
      if (wen && (sel == csr_pkg::SEL_MCAUSE))
        mcause <= wr_value;
      else if (exception)
        mcause <= {exception_int, {(`XLEN-`CAUSE_WIDTH-1){1'b0}}, exception_code};
      if (wen && (sel == csr_pkg::SEL_MTVAL))
        mtval <= wr_value;
      else if (exception && inst_fault)
        mtval <= exception_pc;
      else if (exception && mem_fault)
        mtval <= exception_addr;
    end
  end

endmodule
